/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= sd_cmd_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Test completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "simulation did not pass"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* design/cmd_write.sv */
// command transmitter, serializes index and argument onto CMD and appends CRC7 and end bit
`timescale 1ns/1ps

module cmd_write
  import sd_proto_pkg::*;
(
  input  logic               sd_clk_i,
  input  logic               rst_n_i,
  input  logic               start_i,  // one cycle, index_i and arg_i valid
  input  logic [CmdIdxW-1:0] index_i,
  input  logic [CmdArgW-1:0] arg_i,
  output logic               cmd_o,
  output logic               cmd_oe_o,
  output logic               busy_o,
  output logic               done_o    // cycle after the end bit
);

  localparam int unsigned     CntW     = 6;
  localparam int unsigned     BodyW    = CmdFrameLen - Crc7W - 1; // bits under the CRC
  localparam logic [CntW-1:0] CrcFirst = CntW'(BodyW);
  localparam logic [CntW-1:0] LastBit  = CntW'(CmdFrameLen - 1);

  logic             busy_q;
  logic             done_q;
  logic [BodyW-1:0] frame_q;
  logic [CntW-1:0]  bit_cnt;
  logic [CntW-1:0]  crc_idx;
  logic [Crc7W-1:0] crc;
  logic             in_body;

  assign in_body = busy_q && (bit_cnt < CrcFirst);
  assign crc_idx = CntW'(CmdFrameLen - 2) - bit_cnt; // 6 down to 0 over the CRC field

  always_ff @(posedge sd_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
    end else begin
      done_q <= busy_q && (bit_cnt == LastBit);
      if (start_i && !busy_q) begin
        busy_q <= 1'b1;
      end else if (busy_q && (bit_cnt == LastBit)) begin
        busy_q <= 1'b0;
      end
    end
  end

  // start bit, transmission bit, index, argument
  always_ff @(posedge sd_clk_i) begin
    if (start_i && !busy_q) begin
      frame_q <= {1'b0, 1'b1, index_i, arg_i};
    end else if (busy_q) begin
      frame_q <= frame_q << 1;
    end
  end

  always_comb begin
    if (!busy_q) begin
      cmd_o = 1'b1;                 // idle level
    end else if (in_body) begin
      cmd_o = frame_q[BodyW-1];
    end else if (bit_cnt == LastBit) begin
      cmd_o = 1'b1;                 // end bit
    end else begin
      cmd_o = crc[crc_idx[2:0]];    // CRC7, MSB first
    end
  end

  assign cmd_oe_o = busy_q;
  assign busy_o   = busy_q;
  assign done_o   = done_q;

  crc7_gen i_crc7_gen (
    .clk_i   (sd_clk_i),
    .rst_n_i (rst_n_i),
    .clear_i (~busy_q),
    .en_i    (in_body),
    .dat_i   (frame_q[BodyW-1]),
    .crc_o   (crc)
  );

  counter #(
    .Width (CntW) // 48 bit frame
  ) i_bit_counter (
    .clk_i      (sd_clk_i),
    .rst_n_i    (rst_n_i),
    .clear_i    (~busy_q),
    .en_i       (busy_q),
    .q_o        (bit_cnt),
    .overflow_o ()
  );

endmodule

/* design/counter.sv */
// clearable up counter with a sticky overflow flag, used for frame bit counting
`timescale 1ns/1ps

module counter #(
  parameter int unsigned Width = 8
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             clear_i,    // wins over en_i
  input  logic             en_i,
  output logic [Width-1:0] q_o,
  output logic             overflow_o  // stays set until clear_i
);

  logic [Width-1:0] cnt_q;
  logic             ovf_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
      ovf_q <= 1'b0;
    end else if (clear_i) begin
      cnt_q <= '0;
      ovf_q <= 1'b0;
    end else if (en_i) begin
      cnt_q <= cnt_q + 1'b1;
      if (&cnt_q) ovf_q <= 1'b1; // wrap from all ones
    end
  end

  assign q_o        = cnt_q;
  assign overflow_o = ovf_q;

endmodule

/* design/crc7_gen.sv */
// serial CRC7 accumulator shared by the command transmitter and the response receiver
`timescale 1ns/1ps

module crc7_gen
  import sd_proto_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             clear_i, // back to zero, wins over en_i
  input  logic             en_i,    // one bit per enabled cycle
  input  logic             dat_i,
  output logic [Crc7W-1:0] crc_o
);

  logic [Crc7W-1:0] crc_q;
  logic             feedback;

  assign feedback = dat_i ^ crc_q[Crc7W-1];

  // Galois form: shift left and fold the polynomial in when the feedback bit is set
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      crc_q <= '0;
    end else if (clear_i) begin
      crc_q <= '0;
    end else if (en_i) begin
      crc_q <= {crc_q[Crc7W-2:0], 1'b0} ^ (feedback ? Crc7Poly : '0);
    end
  end

  assign crc_o = crc_q;

endmodule

/* design/rsp_read.sv */
// response receiver, shifts in a short or R2 response and checks its CRC7 and end bit
`timescale 1ns/1ps

module rsp_read
  import sd_proto_pkg::*;
  import sd_cmd_ctrl_pkg::*;
#(
  parameter int unsigned NumBits = 127
) (
  input  logic                   sd_clk_i,
  input  logic                   rst_n_i,
  input  logic                   cmd_i,
  input  rsp_kind_e              rsp_kind_i,        // stable for the whole response
  input  logic                   start_listening_i,
  output logic                   busy_o,
  output logic                   rsp_valid_o,
  output logic                   end_bit_err_o,     // valid with rsp_valid_o
  output logic [RspContentW-1:0] rsp_o,             // zero outside rsp_valid_o
  output logic                   crc_ok_o           // valid with rsp_valid_o
);

  localparam int unsigned CntW = 8; // longest response is 136 bits

  // bit_cnt c samples frame bit c+1, the start bit is taken before counting
  localparam logic [CntW-1:0] ShortShiftStart =
    CntW'(ShortRspLen - (CmdIdxW + CmdArgW + Crc7W) - 2);
  localparam logic [CntW-1:0] ShortCrcStop    = CntW'(ShortCrcSpan - 2);
  localparam logic [CntW-1:0] ShortDone       = CntW'(ShortRspLen - 2);
  localparam logic [CntW-1:0] LongShiftStart  = CntW'(LongRspLen - NumBits - 2);
  localparam logic [CntW-1:0] LongCrcStop     = CntW'(LongRspLen - NumBits - 3 + LongCrcSpan);
  localparam logic [CntW-1:0] LongDone        = CntW'(LongRspLen - 2);

  typedef enum logic [1:0] {
    INACTIVE,
    WAIT_FOR_START_BIT,
    SHIFT_IN,
    FINISHED
  } rx_state_e;

  rx_state_e          state_d, state_q;
  logic               long_rsp;
  logic [CntW-1:0]    bit_cnt;
  logic [CntW-1:0]    shift_start, crc_start, crc_stop, done_cnt;
  logic               shift_en, crc_en, last_bit;
  logic               end_bit_q;
  logic [NumBits-1:0] rsp_with_crc;
  logic [Crc7W-1:0]   crc_calc;

  assign long_rsp    = (rsp_kind_i == RSP_LONG);
  assign shift_start = long_rsp ? LongShiftStart : ShortShiftStart;
  assign crc_start   = long_rsp ? LongShiftStart : '0; // short CRC includes transmission bit
  assign crc_stop    = long_rsp ? LongCrcStop : ShortCrcStop;
  assign done_cnt    = long_rsp ? LongDone : ShortDone;

  assign last_bit = (state_q == SHIFT_IN) && (bit_cnt == done_cnt);
  assign shift_en = (state_q == SHIFT_IN) && (bit_cnt >= shift_start) && !last_bit;
  assign crc_en   = (state_q == SHIFT_IN) && (bit_cnt >= crc_start) && (bit_cnt <= crc_stop);

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      INACTIVE:           if (start_listening_i) state_d = WAIT_FOR_START_BIT;
      WAIT_FOR_START_BIT: if (!cmd_i) state_d = SHIFT_IN; // start bit is 0
      SHIFT_IN:           if (last_bit) state_d = FINISHED;
      FINISHED:           state_d = INACTIVE;
      default:            state_d = INACTIVE;
    endcase
  end

  always_ff @(posedge sd_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= INACTIVE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge sd_clk_i) begin
    if (last_bit) end_bit_q <= cmd_i;
  end

  // short content sits in the low bits, older data above it is dropped
  always_comb begin
    if (long_rsp) begin
      rsp_o = RspContentW'(rsp_with_crc[NumBits-1:Crc7W]);
    end else begin
      rsp_o = RspContentW'(rsp_with_crc[CmdIdxW+CmdArgW+Crc7W-1:Crc7W]);
    end
  end

  assign busy_o        = (state_q != INACTIVE);
  assign rsp_valid_o   = (state_q == FINISHED);
  assign crc_ok_o      = rsp_valid_o && (crc_calc == rsp_with_crc[Crc7W-1:0]);
  assign end_bit_err_o = rsp_valid_o && !end_bit_q;

  ser_par_shift_reg #(
    .NumBits (NumBits)
  ) i_rsp_shift_reg (
    .clk_i           (sd_clk_i),
    .rst_n_i         (rst_n_i),
    .shift_in_en_i   (shift_en),
    .par_output_en_i (rsp_valid_o),
    .dat_ser_i       (cmd_i),
    .dat_par_o       (rsp_with_crc)
  );

  crc7_gen i_crc7_gen (
    .clk_i   (sd_clk_i),
    .rst_n_i (rst_n_i),
    .clear_i (state_q == INACTIVE),
    .en_i    (crc_en),
    .dat_i   (cmd_i),
    .crc_o   (crc_calc)
  );

  counter #(
    .Width (CntW)
  ) i_bit_counter (
    .clk_i      (sd_clk_i),
    .rst_n_i    (rst_n_i),
    .clear_i    (state_q != SHIFT_IN),
    .en_i       (state_q == SHIFT_IN),
    .q_o        (bit_cnt),
    .overflow_o ()
  );

endmodule

/* design/sd_cmd_ctrl_pkg.sv */
// host-side control types for the command path, used to request a response kind
package sd_cmd_ctrl_pkg;

  // which response, if any, follows a command
  typedef enum logic [1:0] {
    RSP_NONE  = 2'd0, // no response expected
    RSP_SHORT = 2'd1, // 48 bit response
    RSP_LONG  = 2'd2  // 136 bit R2 response
  } rsp_kind_e;

endpackage

/* design/sd_cmd_phy.sv */
// SD host CMD line top level, sends a command frame and receives the optional response
`timescale 1ns/1ps

module sd_cmd_phy
  import sd_proto_pkg::*;
  import sd_cmd_ctrl_pkg::*;
#(
  parameter int unsigned RspShiftBits = 127
) (
  input  logic                   sd_clk_i,
  input  logic                   rst_n_i,
  input  logic                   cmd_start_i,       // one cycle pulse, ignored while busy
  input  logic [CmdIdxW-1:0]     cmd_index_i,
  input  logic [CmdArgW-1:0]     cmd_arg_i,
  input  rsp_kind_e              rsp_kind_i,
  input  logic                   cmd_i,
  output logic                   cmd_o,
  output logic                   cmd_oe_o,
  output logic                   cmd_busy_o,
  output logic                   rsp_valid_o,
  output logic [RspContentW-1:0] rsp_o,
  output logic                   rsp_crc_ok_o,
  output logic                   rsp_end_bit_err_o
);

  rsp_kind_e rsp_kind_q;
  logic      cmd_start;
  logic      wr_busy, wr_done, rd_busy;
  logic      start_listening;

  assign cmd_start       = cmd_start_i && !cmd_busy_o;
  assign start_listening = wr_done && (rsp_kind_q != RSP_NONE);
  assign cmd_busy_o      = wr_busy || wr_done || rd_busy; // done cycle bridges to the reader

  always_ff @(posedge sd_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_kind_q <= RSP_NONE;
    end else if (cmd_start) begin
      rsp_kind_q <= rsp_kind_i;
    end
  end

  cmd_write i_cmd_write (
    .sd_clk_i (sd_clk_i),
    .rst_n_i  (rst_n_i),
    .start_i  (cmd_start),
    .index_i  (cmd_index_i),
    .arg_i    (cmd_arg_i),
    .cmd_o    (cmd_o),
    .cmd_oe_o (cmd_oe_o),
    .busy_o   (wr_busy),
    .done_o   (wr_done)
  );

  rsp_read #(
    .NumBits (RspShiftBits)
  ) i_rsp_read (
    .sd_clk_i          (sd_clk_i),
    .rst_n_i           (rst_n_i),
    .cmd_i             (cmd_i),
    .rsp_kind_i        (rsp_kind_q),
    .start_listening_i (start_listening),
    .busy_o            (rd_busy),
    .rsp_valid_o       (rsp_valid_o),
    .end_bit_err_o     (rsp_end_bit_err_o),
    .rsp_o             (rsp_o),
    .crc_ok_o          (rsp_crc_ok_o)
  );

endmodule

/* design/sd_proto_pkg.sv */
// SD command protocol constants: field widths, frame lengths and the CRC7 polynomial
package sd_proto_pkg;

  // command fields
  localparam int unsigned CmdIdxW = 6;
  localparam int unsigned CmdArgW = 32;
  localparam int unsigned Crc7W   = 7;

  // frame lengths on the CMD line, start and end bit included
  localparam int unsigned CmdFrameLen = 48;
  localparam int unsigned ShortRspLen = 48;
  localparam int unsigned LongRspLen  = 136;

  // parallel response width, R2 content without CRC
  localparam int unsigned RspContentW = 120;

  // bits covered by the CRC7 of each response kind
  localparam int unsigned ShortCrcSpan = 40;  // start, transmission, index, argument
  localparam int unsigned LongCrcSpan  = 120; // content bits only

  localparam logic [Crc7W-1:0] Crc7Poly = 7'h09; // x^7 + x^3 + 1

endpackage

/* design/ser_par_shift_reg.sv */
// serial-in parallel-out shift register, parallel output held at zero until enabled
`timescale 1ns/1ps

module ser_par_shift_reg #(
  parameter int unsigned NumBits = 127
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               shift_in_en_i,
  input  logic               par_output_en_i,
  input  logic               dat_ser_i,
  output logic [NumBits-1:0] dat_par_o
);

  logic [NumBits-1:0] dat_q;

  // first received bit ends up at the MSB
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      dat_q <= '0;
    end else if (shift_in_en_i) begin
      dat_q <= {dat_q[NumBits-2:0], dat_ser_i};
    end
  end

  // the wide output only toggles once the frame is complete
  always_comb begin
    if (par_output_en_i) begin
      dat_par_o = dat_q;
    end else begin
      dat_par_o = '0;
    end
  end

endmodule

/* project.f */
design/sd_proto_pkg.sv
design/sd_cmd_ctrl_pkg.sv
design/counter.sv
design/crc7_gen.sv
design/ser_par_shift_reg.sv
design/cmd_write.sv
design/rsp_read.sv
design/sd_cmd_phy.sv
verif/tb_clk_gen.sv
verif/sd_cmd_tb.sv

/* verif/sd_cmd_tb.sv */
// testbench for the SD CMD line top level with a card model and concurrent output checks
`timescale 1ns/1ps

module sd_cmd_tb
  import sd_proto_pkg::*;
  import sd_cmd_ctrl_pkg::*;
;

  localparam int unsigned NumTests = 12;
  localparam int unsigned ClkPeriod = 10;
  localparam int unsigned MinDelay = 2;
  localparam int unsigned MaxDelay = 8;

  logic clk, rst_n;
  logic cmd_start_i, cmd_i;
  logic [CmdIdxW-1:0] cmd_index_i;
  logic [CmdArgW-1:0] cmd_arg_i;
  rsp_kind_e rsp_kind_i;
  logic cmd_o, cmd_oe_o, cmd_busy_o, rsp_valid_o, rsp_crc_ok_o, rsp_end_bit_err_o;
  logic [RspContentW-1:0] rsp_o;

  logic [CmdFrameLen-1:0] exp_frame;
  logic [RspContentW-1:0] exp_rsp;
  logic exp_crc_ok, exp_end_err, rsp_expected, start_q;
  logic cmd_issued;
  rsp_kind_e kind_q;
  int oe_cnt;
  int mismatch_errs = 0;
  int other_errs = 0;

  tb_clk_gen #(.PeriodNs(ClkPeriod), .RstCycles(3)) i_clk_gen (.clk_o(clk), .rst_n_o(rst_n));

  sd_cmd_phy dut (
    .sd_clk_i (clk), .rst_n_i (rst_n), .cmd_start_i (cmd_start_i),
    .cmd_index_i (cmd_index_i), .cmd_arg_i (cmd_arg_i), .rsp_kind_i (rsp_kind_i),
    .cmd_i (cmd_i), .cmd_o (cmd_o), .cmd_oe_o (cmd_oe_o), .cmd_busy_o (cmd_busy_o),
    .rsp_valid_o (rsp_valid_o), .rsp_o (rsp_o), .rsp_crc_ok_o (rsp_crc_ok_o),
    .rsp_end_bit_err_o (rsp_end_bit_err_o)
  );

  // CRC7 from x^7 + x^3 + 1 taken MSB of the span first
  function automatic logic [6:0] crc7(input logic [119:0] d, input int n);
    logic [6:0] c;
    logic fb;
    c = '0;
    for (int k = n - 1; k >= 0; k--) begin
      fb = d[k] ^ c[6];
      c = {c[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
    end
    return c;
  endfunction

  function automatic void report_failure(input string what);
    other_errs++;
    $display("%0t: %s", $time, what);
  endfunction

  function automatic void report_mismatch(input string name,
                                          input logic [RspContentW-1:0] exp_val,
                                          input logic [RspContentW-1:0] got_val);
    mismatch_errs++;
    $display("mismatch at %0t: %s expected 0x%0h got 0x%0h", $time, name, exp_val, got_val);
  endfunction

  // bit position inside the frame that restarts with each issued command
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      start_q <= 1'b0;
      oe_cnt  <= 0;
      kind_q  <= RSP_NONE;
    end else begin
      start_q <= cmd_issued;
      if (cmd_issued) begin
        oe_cnt <= 0;
        kind_q <= rsp_kind_i;
      end else if (cmd_oe_o) begin
        oe_cnt <= oe_cnt + 1;
      end
    end
  end

  assert property (@(posedge clk) !rst_n |-> (!cmd_oe_o && !cmd_busy_o && !rsp_valid_o))
    else report_failure("outputs not low during reset");
  assert property (@(posedge clk) disable iff (!rst_n) start_q |-> cmd_oe_o)
    else report_failure("frame did not start after cmd_start_i");
  assert property (@(posedge clk) disable iff (!rst_n) cmd_oe_o |-> oe_cnt < CmdFrameLen)
    else report_failure("cmd_oe_o high beyond 48 bits");
  assert property (@(posedge clk) disable iff (!rst_n)
                   $fell(cmd_oe_o) |-> oe_cnt == CmdFrameLen)
    else report_mismatch("cmd_oe_o cycles", CmdFrameLen, $sampled(oe_cnt));
  assert property (@(posedge clk) disable iff (!rst_n)
                   cmd_oe_o |-> cmd_o == exp_frame[CmdFrameLen-1-oe_cnt])
    else report_mismatch($sformatf("cmd_o bit %0d", $sampled(oe_cnt)),
                         exp_frame[CmdFrameLen-1-$sampled(oe_cnt)], $sampled(cmd_o));
  assert property (@(posedge clk) disable iff (!rst_n)
                   ($fell(cmd_oe_o) && kind_q == RSP_NONE) |=> !cmd_busy_o)
    else report_failure("cmd_busy_o stuck after frame");
  assert property (@(posedge clk) disable iff (!rst_n) rsp_valid_o |-> rsp_expected)
    else report_failure("unexpected rsp_valid_o pulse");
  assert property (@(posedge clk) disable iff (!rst_n) rsp_valid_o |-> rsp_o == exp_rsp)
    else report_mismatch("rsp_o", exp_rsp, $sampled(rsp_o));
  assert property (@(posedge clk) disable iff (!rst_n) !rsp_valid_o |-> rsp_o == '0)
    else report_mismatch("rsp_o", '0, $sampled(rsp_o));
  assert property (@(posedge clk) disable iff (!rst_n)
                   rsp_valid_o |-> rsp_crc_ok_o == exp_crc_ok)
    else report_mismatch("rsp_crc_ok_o", exp_crc_ok, $sampled(rsp_crc_ok_o));
  assert property (@(posedge clk) disable iff (!rst_n)
                   rsp_valid_o |-> rsp_end_bit_err_o == exp_end_err)
    else report_mismatch("rsp_end_bit_err_o", exp_end_err, $sampled(rsp_end_bit_err_o));

  task automatic issue_cmd(input rsp_kind_e kind);
    logic [ShortCrcSpan-1:0] body;
    cmd_index_i = CmdIdxW'($urandom);
    cmd_arg_i   = $urandom;
    rsp_kind_i  = kind;
    body        = {1'b0, 1'b1, cmd_index_i, cmd_arg_i};
    exp_frame   = {body, crc7(120'(body), ShortCrcSpan), 1'b1};
    cmd_issued  = 1'b1;
    cmd_start_i = 1'b1;
    @(posedge clk);
    #1;
    cmd_issued  = 1'b0;
    cmd_start_i = 1'b0;
  endtask

  // card side that answers after the frame ends and a random delay
  task automatic send_rsp(input rsp_kind_e kind, input logic bad_crc, input logic bad_end);
    logic [LongRspLen-1:0] frm;
    logic [ShortCrcSpan-1:0] body;
    logic [RspContentW-1:0] content;
    logic [6:0] crc;
    int n;
    int delay;
    while (!cmd_oe_o) @(posedge clk);
    while (cmd_oe_o) @(posedge clk);
    delay = MinDelay + ($urandom % (MaxDelay - MinDelay + 1));
    if (kind == RSP_SHORT) begin
      body = {2'b00, 6'($urandom), 32'($urandom)};
      crc = crc7(120'(body), ShortCrcSpan) ^ (bad_crc ? 7'h01 : 7'h00);
      frm = {88'b0, body, crc, ~bad_end};
      n = ShortRspLen;
      exp_rsp = 120'(body[37:0]);
    end else begin
      content = {$urandom, $urandom, $urandom, 24'($urandom)};
      crc = crc7(content, LongCrcSpan) ^ (bad_crc ? 7'h01 : 7'h00);
      frm = {2'b00, 6'h3f, content, crc, ~bad_end};
      n = LongRspLen;
      exp_rsp = content;
    end
    exp_crc_ok = !bad_crc;
    exp_end_err = bad_end;
    rsp_expected = 1'b1;
    repeat (delay) @(posedge clk);
    #1;
    for (int j = 0; j < n; j++) begin
      cmd_i = frm[n-1-j];
      @(posedge clk);
      #1;
    end
    cmd_i = 1'b1;
    while (!rsp_valid_o) @(posedge clk);
    @(posedge clk);
    #1 rsp_expected = 1'b0;
  endtask

  initial begin
    cmd_start_i  = 1'b0;
    cmd_issued   = 1'b0;
    cmd_i        = 1'b1;
    cmd_index_i  = '0;
    cmd_arg_i    = '0;
    rsp_kind_i   = RSP_NONE;
    rsp_expected = 1'b0;
    exp_rsp      = '0;
    exp_frame    = '1;
    exp_crc_ok   = 1'b1;
    exp_end_err  = 1'b0;
    void'($urandom(32'hab3a));
    @(posedge rst_n);
    repeat (2) @(posedge clk);
    #1;
    for (int i = 0; i < NumTests; i++) begin
      rsp_kind_e kind;
      kind = rsp_kind_e'(i % 3);
      issue_cmd(kind);
      if (kind == RSP_NONE) begin
        repeat (10) @(posedge clk);
        #1;
        rsp_kind_i  = RSP_SHORT; // must not replace the registered kind
        cmd_start_i = 1'b1;      // must be ignored while busy
        @(posedge clk);
        #1 cmd_start_i = 1'b0;
        while (cmd_busy_o) @(posedge clk);
        #1;
      end else begin
        send_rsp(kind, (i == 4) || (i == 8), i == 7);
      end
      repeat (3) @(posedge clk);
      #1;
    end
    $display("errors: %0d mismatches, %0d other failures", mismatch_errs, other_errs);
    if (mismatch_errs + other_errs == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin
    #(NumTests * 200 * ClkPeriod);
    $display("watchdog expired before all tests finished");
    $display("errors: %0d mismatches, %0d other failures", mismatch_errs, other_errs);
    $display("Test failed");
    $finish;
  end

endmodule

/* verif/tb_clk_gen.sv */
// testbench clock and reset source, 10 ns clock and reset held low for the first cycles
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int unsigned PeriodNs  = 10,
  parameter int unsigned RstCycles = 3
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (RstCycles) @(posedge clk_o);
    #1 rst_n_o = 1'b1; // release off the edge like the other inputs
  end

endmodule
